// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbCpu
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
logic/cpuPkg.sv
logic/cpuCtrlIf.sv
logic/busPacer.sv
logic/opcodeDecoder.sv
logic/cycleSequencer.sv
logic/dataflow.sv
logic/cpuTop.sv
test/tbClock.sv
test/tbCpu.sv

// ==== logic/busPacer.sv ====
module busPacer #(
    parameter int BUS_DIVIDE = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic ready,
    output logic step
);
    localparam int COUNT_W = (BUS_DIVIDE > 1) ? $clog2(BUS_DIVIDE) : 1;
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(BUS_DIVIDE - 1);

    logic [COUNT_W-1:0] count;
    logic               terminal;

    assign terminal = (count == LAST_COUNT);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (terminal) begin
            count <= '0;
        end else begin
            count <= count + 1'b1; // free running, ready does not hold it.
        end
    end

    // a bus cycle completes only on the slow pulse with the memory ready.
    assign step = terminal & ready;

endmodule

// ==== logic/cpuCtrlIf.sv ====
interface cpuCtrlIf;
    logic          loadOpcode;
    logic          loadOperandLow;
    logic          loadOperandHigh;
    logic          pcIncrement;
    logic          pcLoadAbsolute;
    logic          pcLoadBranch;
    logic          addrFromPc;
    logic          addrFromOperand;
    logic          addrFromVector;
    logic          vectorHigh;
    logic          loadAccumulator;
    cpuPkg::aluOpT aluOp;
    logic          setCarry;
    logic          clearCarry;
    logic          writeAccumulator;

    logic          zeroFlag;
    logic          branchPageCross; // target lies on another page.
    logic          branchBackward;

    modport seq (
        output loadOpcode, loadOperandLow, loadOperandHigh, pcIncrement, pcLoadAbsolute,
        output pcLoadBranch, addrFromPc, addrFromOperand, addrFromVector, vectorHigh,
        output loadAccumulator, aluOp, setCarry, clearCarry, writeAccumulator,
        input  zeroFlag, branchPageCross, branchBackward
    );

    modport path (
        input  loadOpcode, loadOperandLow, loadOperandHigh, pcIncrement, pcLoadAbsolute,
        input  pcLoadBranch, addrFromPc, addrFromOperand, addrFromVector, vectorHigh,
        input  loadAccumulator, aluOp, setCarry, clearCarry, writeAccumulator,
        output zeroFlag, branchPageCross, branchBackward
    );
endinterface

// ==== logic/cpuPkg.sv ====
package cpuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;

    localparam addrT RESET_VECTOR = 16'hFFFC; // low byte of the start address.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        opLda,
        opSta,
        opAdc,
        opAnd,
        opOra,
        opEor,
        opJmp,
        opBeq,
        opBne,
        opClc,
        opSec,
        opNop,
        opIllegal
    } opClassT;

    typedef enum logic [1:0] {
        modeImplied,
        modeImmediate,
        modeAbsolute,
        modeRelative
    } addrModeT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        stReset0,
        stReset1,
        stFetch,
        stOperandLow,
        stOperandHigh,
        stExecute,
        stBranchAdd,
        stBranchFix
    } seqStateT;

    typedef enum logic [2:0] {
        aluPass,
        aluAdc,
        aluAnd,
        aluOra,
        aluEor
    } aluOpT;

endpackage

// ==== logic/cpuTop.sv ====
module cpuTop #(
    parameter int BUS_DIVIDE = 2
) (
    input  logic         clk,
    input  logic         rstN,
    input  cpuPkg::byteT dataIn,
    input  logic         ready,
    output cpuPkg::addrT address,
    output cpuPkg::byteT dataOut,
    output logic         readNotWrite,
    output logic         sync
);
    logic             step;
    cpuPkg::byteT     opcode;
    cpuPkg::opClassT  opClass;
    cpuPkg::addrModeT addrMode;

    cpuCtrlIf ctrlBus ();

    busPacer #(
        .BUS_DIVIDE(BUS_DIVIDE)
    ) u_busPacer (
        .clk  (clk),
        .rstN (rstN),
        .ready(ready),
        .step (step)
    );

    opcodeDecoder u_opcodeDecoder (
        .opcode  (opcode),
        .opClass (opClass),
        .addrMode(addrMode)
    );

    cycleSequencer u_cycleSequencer (
        .clk         (clk),
        .rstN        (rstN),
        .step        (step),
        .opcode      (opcode),
        .opClass     (opClass),
        .addrMode    (addrMode),
        .ctrl        (ctrlBus.seq),
        .readNotWrite(readNotWrite),
        .sync        (sync)
    );

    dataflow u_dataflow (
        .clk    (clk),
        .rstN   (rstN),
        .step   (step),
        .ctrl   (ctrlBus.path),
        .dataIn (dataIn),
        .dataOut(dataOut),
        .address(address),
        .opcode (opcode)
    );

endmodule

// ==== logic/cycleSequencer.sv ====
module cycleSequencer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             step,
    input  cpuPkg::byteT     opcode,
    input  cpuPkg::opClassT  opClass,
    input  cpuPkg::addrModeT addrMode,
    cpuCtrlIf.seq            ctrl,
    output logic             readNotWrite,
    output logic             sync
);
    cpuPkg::seqStateT state;
    cpuPkg::seqStateT nextState;
    cpuPkg::aluOpT    groupOneOp;
    logic             branchTaken;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= cpuPkg::stReset0;
        end else if (step) begin
            state <= nextState;
        end
    end

    // the aaa field of the group one opcodes picks the alu function.
    always_comb begin
        case (opcode[7:5])
            3'b000:  groupOneOp = cpuPkg::aluOra;
            3'b001:  groupOneOp = cpuPkg::aluAnd;
            3'b010:  groupOneOp = cpuPkg::aluEor;
            3'b011:  groupOneOp = cpuPkg::aluAdc;
            default: groupOneOp = cpuPkg::aluPass; // lda.
        endcase
    end

    assign branchTaken = ((opClass == cpuPkg::opBeq) && ctrl.zeroFlag) ||
                         ((opClass == cpuPkg::opBne) && !ctrl.zeroFlag);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per state control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        nextState             = state;
        ctrl.loadOpcode       = 1'b0;
        ctrl.loadOperandLow   = 1'b0;
        ctrl.loadOperandHigh  = 1'b0;
        ctrl.pcIncrement      = 1'b0;
        ctrl.pcLoadAbsolute   = 1'b0;
        ctrl.pcLoadBranch     = 1'b0;
        ctrl.addrFromPc       = 1'b0;
        ctrl.addrFromOperand  = 1'b0;
        ctrl.addrFromVector   = 1'b0;
        ctrl.vectorHigh       = 1'b0;
        ctrl.loadAccumulator  = 1'b0;
        ctrl.aluOp            = groupOneOp;
        ctrl.setCarry         = 1'b0;
        ctrl.clearCarry       = 1'b0;
        ctrl.writeAccumulator = 1'b0;

        case (state)
            cpuPkg::stReset0: begin
                ctrl.addrFromVector = 1'b1;
                ctrl.loadOperandLow = 1'b1; // low byte of the start address.
                nextState           = cpuPkg::stReset1;
            end
            cpuPkg::stReset1: begin
                ctrl.addrFromVector = 1'b1;
                ctrl.vectorHigh     = 1'b1;
                ctrl.pcLoadAbsolute = 1'b1;
                nextState           = cpuPkg::stFetch;
            end
            cpuPkg::stFetch: begin
                ctrl.addrFromPc  = 1'b1;
                ctrl.loadOpcode  = 1'b1;
                ctrl.pcIncrement = 1'b1;
                nextState        = cpuPkg::stOperandLow;
            end
            cpuPkg::stOperandLow: begin
                ctrl.addrFromPc = 1'b1;
                nextState       = cpuPkg::stFetch;
                case (addrMode)
                    cpuPkg::modeImmediate: begin
                        ctrl.loadAccumulator = 1'b1;
                        ctrl.pcIncrement     = 1'b1;
                    end
                    cpuPkg::modeAbsolute: begin
                        ctrl.loadOperandLow = 1'b1;
                        ctrl.pcIncrement    = 1'b1;
                        nextState           = cpuPkg::stOperandHigh;
                    end
                    cpuPkg::modeRelative: begin
                        ctrl.loadOperandLow = 1'b1; // the signed offset.
                        ctrl.pcIncrement    = 1'b1;
                        if (branchTaken) begin
                            nextState = cpuPkg::stBranchAdd;
                        end
                    end
                    default: begin
                        // Implied ops spend this cycle on a dummy read.
                        ctrl.setCarry   = (opClass == cpuPkg::opSec);
                        ctrl.clearCarry = (opClass == cpuPkg::opClc);
                    end
                endcase
            end
            cpuPkg::stOperandHigh: begin
                ctrl.addrFromPc = 1'b1;
                if (opClass == cpuPkg::opJmp) begin
                    ctrl.pcLoadAbsolute = 1'b1;
                    nextState           = cpuPkg::stFetch;
                end else begin
                    ctrl.loadOperandHigh = 1'b1;
                    ctrl.pcIncrement     = 1'b1;
                    nextState            = cpuPkg::stExecute;
                end
            end
            cpuPkg::stExecute: begin
                ctrl.addrFromOperand = 1'b1;
                if (opClass == cpuPkg::opSta) begin
                    ctrl.writeAccumulator = 1'b1;
                end else begin
                    ctrl.loadAccumulator = 1'b1;
                end
                nextState = cpuPkg::stFetch;
            end
            cpuPkg::stBranchAdd: begin
                ctrl.addrFromPc   = 1'b1;
                ctrl.pcLoadBranch = 1'b1;
                nextState = ctrl.branchPageCross ? cpuPkg::stBranchFix : cpuPkg::stFetch;
            end
            cpuPkg::stBranchFix: begin
                ctrl.addrFromPc   = 1'b1;
                ctrl.pcLoadBranch = 1'b1; // second pass corrects the high byte.
                nextState         = cpuPkg::stFetch;
            end
            default: begin
                nextState = cpuPkg::stReset0;
            end
        endcase
    end

    assign readNotWrite = ~ctrl.writeAccumulator;
    assign sync         = (state == cpuPkg::stFetch);

endmodule

// ==== logic/dataflow.sv ====
module dataflow (
    input  logic         clk,
    input  logic         rstN,
    input  logic         step,
    cpuCtrlIf.path       ctrl,
    input  cpuPkg::byteT dataIn,
    output cpuPkg::byteT dataOut,
    output cpuPkg::addrT address,
    output cpuPkg::byteT opcode
);
    cpuPkg::addrT pc;
    cpuPkg::byteT opcodeReg;
    cpuPkg::byteT operandLow;
    cpuPkg::byteT operandHigh;
    cpuPkg::byteT accumulator;
    logic         negativeFlag;
    logic         zeroReg;
    logic         carryFlag;

    cpuPkg::byteT aluResult;
    logic [8:0]   adcSum;
    logic [8:0]   branchLowSum;
    logic         fixPending;
    cpuPkg::addrT operandAddress;
    cpuPkg::addrT vectorAddress;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and data bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign operandAddress = {operandHigh, operandLow};
    assign vectorAddress  = {cpuPkg::RESET_VECTOR[15:1], ctrl.vectorHigh};

    assign address = ({16{ctrl.addrFromPc}}      & pc) |
                     ({16{ctrl.addrFromOperand}} & operandAddress) |
                     ({16{ctrl.addrFromVector}}  & vectorAddress);

    assign dataOut = ctrl.writeAccumulator ? accumulator : 8'h00;
    assign opcode  = opcodeReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign adcSum = {1'b0, accumulator} + {1'b0, dataIn} + {8'h00, carryFlag};

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdc: aluResult = adcSum[7:0];
            cpuPkg::aluAnd: aluResult = accumulator & dataIn;
            cpuPkg::aluOra: aluResult = accumulator | dataIn;
            cpuPkg::aluEor: aluResult = accumulator ^ dataIn;
            default:        aluResult = dataIn;
        endcase
    end

    always_ff @(posedge clk) begin
        if (step && ctrl.loadAccumulator) begin
            accumulator  <= aluResult;
            negativeFlag <= aluResult[7];
            zeroReg      <= (aluResult == 8'h00);
        end
        if (step) begin
            if (ctrl.loadAccumulator && (ctrl.aluOp == cpuPkg::aluAdc)) begin
                carryFlag <= adcSum[8];
            end else if (ctrl.setCarry) begin
                carryFlag <= 1'b1;
            end else if (ctrl.clearCarry) begin
                carryFlag <= 1'b0;
            end
        end
    end

    assign ctrl.zeroFlag = zeroReg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program counter and latches
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The offset goes onto the low byte only; a carry or borrow out of it
    // means the high byte is fixed up one step later.
    assign branchLowSum         = {1'b0, pc[7:0]} + {1'b0, operandLow};
    assign ctrl.branchBackward  = operandLow[7];
    assign ctrl.branchPageCross = operandLow[7] ? ~branchLowSum[8] : branchLowSum[8];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fixPending <= 1'b0;
        end else if (step && ctrl.pcLoadBranch) begin
            fixPending <= !fixPending && ctrl.branchPageCross;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if (ctrl.pcLoadAbsolute) begin
                pc <= {dataIn, operandLow};
            end else if (ctrl.pcLoadBranch) begin
                if (fixPending) begin
                    pc[15:8] <= ctrl.branchBackward ? pc[15:8] - 8'd1 : pc[15:8] + 8'd1;
                end else begin
                    pc[7:0] <= branchLowSum[7:0];
                end
            end else if (ctrl.pcIncrement) begin
                pc <= pc + 16'd1;
            end
            if (ctrl.loadOpcode) begin
                opcodeReg <= dataIn;
            end
            if (ctrl.loadOperandLow) begin
                operandLow <= dataIn;
            end
            if (ctrl.loadOperandHigh) begin
                operandHigh <= dataIn;
            end
        end
    end

endmodule

// ==== logic/opcodeDecoder.sv ====
module opcodeDecoder (
    input  cpuPkg::byteT     opcode,
    output cpuPkg::opClassT  opClass,
    output cpuPkg::addrModeT addrMode
);
    always_comb begin
        case (opcode)
            8'hA9: begin
                opClass  = cpuPkg::opLda;
                addrMode = cpuPkg::modeImmediate;
            end
            8'hAD: begin
                opClass  = cpuPkg::opLda;
                addrMode = cpuPkg::modeAbsolute;
            end
            8'h8D: begin
                opClass  = cpuPkg::opSta;
                addrMode = cpuPkg::modeAbsolute;
            end
            8'h69: begin
                opClass  = cpuPkg::opAdc;
                addrMode = cpuPkg::modeImmediate;
            end
            8'h29: begin
                opClass  = cpuPkg::opAnd;
                addrMode = cpuPkg::modeImmediate;
            end
            8'h09: begin
                opClass  = cpuPkg::opOra;
                addrMode = cpuPkg::modeImmediate;
            end
            8'h49: begin
                opClass  = cpuPkg::opEor;
                addrMode = cpuPkg::modeImmediate;
            end
            8'h4C: begin
                opClass  = cpuPkg::opJmp;
                addrMode = cpuPkg::modeAbsolute;
            end
            8'hF0: begin
                opClass  = cpuPkg::opBeq;
                addrMode = cpuPkg::modeRelative;
            end
            8'hD0: begin
                opClass  = cpuPkg::opBne;
                addrMode = cpuPkg::modeRelative;
            end
            8'h18: begin
                opClass  = cpuPkg::opClc;
                addrMode = cpuPkg::modeImplied;
            end
            8'h38: begin
                opClass  = cpuPkg::opSec;
                addrMode = cpuPkg::modeImplied;
            end
            8'hEA: begin
                opClass  = cpuPkg::opNop;
                addrMode = cpuPkg::modeImplied;
            end
            default: begin
                opClass  = cpuPkg::opIllegal; // runs as a two cycle nop.
                addrMode = cpuPkg::modeImplied;
            end
        endcase
    end

endmodule

// ==== test/tbClock.sv ====
module tbClock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1; // released just after the edge, like the other inputs.
    end

endmodule

// ==== test/tbCpu.sv ====
module tbCpu;
    localparam int BUS_DIVIDE = 2;
    localparam int MAX_INSTR  = 60;
    localparam cpuPkg::addrT START_PC = 16'h02F0;

    logic         clk;
    logic         rstN;
    logic         ready;
    cpuPkg::byteT dataIn;
    cpuPkg::addrT address;
    cpuPkg::byteT dataOut;
    logic         readNotWrite;
    logic         sync;

    cpuPkg::byteT mem [0:65535];
    cpuPkg::byteT refMem [0:65535];
    cpuPkg::addrT storeAddrQ [$];
    cpuPkg::byteT storeDataQ [$];

    int           seed;
    int           instrCount;
    int           addrErrors;
    int           byteErrors;
    int           bitErrors;
    int           otherErrors;
    logic         genDone;
    logic         endReached;
    cpuPkg::addrT genPc;
    cpuPkg::addrT endPc;

    cpuPkg::addrT refPc;
    cpuPkg::byteT refA;
    logic         refN;
    logic         refZ;
    logic         refC;
    cpuPkg::addrT fetchPc;
    cpuPkg::addrT storeAddr;
    cpuPkg::byteT storeData;

    logic         havePrev;
    logic         firstFetch;
    logic         prevReady;
    logic         prevRnw;
    logic         prevSync;
    cpuPkg::addrT prevAddress;
    cpuPkg::byteT prevDataOut;

    tbClock u_tbClock (
        .clk (clk),
        .rstN(rstN)
    );

    cpuTop #(
        .BUS_DIVIDE(BUS_DIVIDE)
    ) u_cpuTop (
        .clk         (clk),
        .rstN        (rstN),
        .dataIn      (dataIn),
        .ready       (ready),
        .address     (address),
        .dataOut     (dataOut),
        .readNotWrite(readNotWrite),
        .sync        (sync)
    );

    assign dataIn = mem[address]; // asynchronous read memory.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkAddr(input cpuPkg::addrT actual, input cpuPkg::addrT expected,
                             input string what);
        if (actual !== expected) begin
            addrErrors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkByte(input cpuPkg::byteT actual, input cpuPkg::byteT expected,
                             input string what);
        if (actual !== expected) begin
            byteErrors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            bitErrors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic cpuPkg::byteT randomByte();
        return cpuPkg::byteT'($random(seed));
    endfunction

    task automatic emitByte(input cpuPkg::byteT value);
        mem[genPc] = value;
        genPc      = genPc + 16'd1;
    endtask

    task automatic buildProgram();
        int           kind;
        int           skip;
        cpuPkg::addrT target;
        genPc = START_PC;
        emitByte(8'hA9);
        emitByte(8'h00);
        emitByte(8'h18); // carry and Z are known from here on.
        instrCount = 2;
        while (genPc != 16'h02FC) begin
            emitByte(8'hEA);
            instrCount++;
        end
        // A taken BEQ here lands on 0301, one page up.
        emitByte(8'hF0);
        emitByte(8'h03);
        repeat (3) emitByte(8'hEA);
        instrCount += 4;
        while ((instrCount < MAX_INSTR) && (genPc < 16'h03F0)) begin
            kind = int'($unsigned($random(seed)) % 11);
            skip = int'($unsigned($random(seed)) % 4);
            instrCount++;
            case (kind)
                1, 2, 3: begin
                    emitByte((kind == 1) ? 8'hAD : 8'h8D);
                    emitByte(randomByte());
                    emitByte(8'h04);
                end
                8: begin
                    emitByte((skip == 0) ? 8'h18 : ((skip == 1) ? 8'h38 : 8'hEA));
                end
                9: begin
                    emitByte((randomByte() < 8'h80) ? 8'hF0 : 8'hD0);
                    emitByte(cpuPkg::byteT'(skip));
                    repeat (skip) emitByte(8'hEA); // both ways reach real code.
                    instrCount += skip;
                end
                10: begin
                    target = genPc + 16'd3 + cpuPkg::addrT'(skip);
                    emitByte(8'h4C);
                    emitByte(target[7:0]);
                    emitByte(target[15:8]);
                    repeat (skip) emitByte(randomByte());
                end
                default: begin
                    emitByte((kind == 0) ? 8'hA9 : ((kind == 4) ? 8'h69 :
                             ((kind == 5) ? 8'h29 : ((kind == 6) ? 8'h09 : 8'h49))));
                    emitByte((skip == 0) ? 8'h00 : randomByte()); // zero now and then.
                end
            endcase
        end
        endPc = genPc;
        emitByte(8'h4C);
        emitByte(endPc[7:0]);
        emitByte(endPc[15:8]);
        instrCount++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic setAccumulator(input cpuPkg::byteT value);
        refA = value;
        refN = value[7];
        refZ = (value == 8'h00);
    endtask

    task automatic stepModel();
        cpuPkg::byteT op;
        cpuPkg::byteT lo;
        cpuPkg::byteT hi;
        int           total;
        op = refMem[refPc];
        lo = refMem[refPc + 16'd1];
        hi = refMem[refPc + 16'd2];
        refPc = refPc + 16'd2; // most of the subset is two bytes long.
        case (op)
            8'hA9: setAccumulator(lo);
            8'h29: setAccumulator(refA & lo);
            8'h09: setAccumulator(refA | lo);
            8'h49: setAccumulator(refA ^ lo);
            8'h69: begin
                total = int'(refA) + int'(lo) + (refC ? 1 : 0);
                refC  = (total > 255);
                setAccumulator(cpuPkg::byteT'(total));
            end
            8'hAD: begin
                setAccumulator(refMem[{hi, lo}]);
                refPc = refPc + 16'd1;
            end
            8'h8D: begin
                refMem[{hi, lo}] = refA;
                storeAddrQ.push_back({hi, lo});
                storeDataQ.push_back(refA);
                refPc = refPc + 16'd1;
            end
            8'h4C: refPc = {hi, lo};
            8'hF0, 8'hD0: begin
                if ((op == 8'hF0) == refZ) begin
                    refPc = refPc + {{8{lo[7]}}, lo};
                end
            end
            8'h18: begin
                refC  = 1'b0;
                refPc = refPc - 16'd1;
            end
            8'h38: begin
                refC  = 1'b1;
                refPc = refPc - 16'd1;
            end
            default: refPc = refPc - 16'd1; // one byte, like NOP.
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic sampleCycle();
        if (!rstN) begin
            checkBit(readNotWrite, 1'b1, "readNotWrite in reset");
            checkBit(sync, 1'b0, "sync in reset");
        end else begin
            if (havePrev && !prevReady) begin
                checkAddr(address, prevAddress, "address while not ready");
                checkByte(dataOut, prevDataOut, "dataOut while not ready");
                checkBit(readNotWrite, prevRnw, "readNotWrite while not ready");
                checkBit(sync, prevSync, "sync while not ready");
            end
            if (sync && !prevSync) begin
                if (firstFetch) begin
                    checkAddr(address, START_PC, "first fetch after reset");
                    firstFetch = 1'b0;
                end
                fetchPc = refPc;
                checkAddr(address, fetchPc, "opcode fetch address");
                if (fetchPc == endPc) begin
                    endReached = 1'b1;
                end else begin
                    stepModel();
                end
            end else if (sync && ready) begin
                checkAddr(address, fetchPc, "opcode fetch address");
            end
            if (!readNotWrite) begin
                if (prevRnw && (storeAddrQ.size() == 0)) begin
                    otherErrors++;
                    $display("write to %h at %0t without a pending store", address, $time);
                end else if (prevRnw) begin
                    storeAddr = storeAddrQ.pop_front();
                    storeData = storeDataQ.pop_front();
                end
                checkAddr(address, storeAddr, "store address");
                checkByte(dataOut, storeData, "store data");
                if (ready) begin
                    mem[address] = dataOut;
                end
            end
            havePrev    = 1'b1;
            prevReady   = ready;
            prevRnw     = readNotWrite;
            prevSync    = sync;
            prevAddress = address;
            prevDataOut = dataOut;
        end
    endtask

    initial begin
        int a;
        seed        = 32'h8bfc;
        ready       = 1'b1;
        genDone     = 1'b0;
        endReached  = 1'b0;
        addrErrors  = 0;
        byteErrors  = 0;
        bitErrors   = 0;
        otherErrors = 0;
        havePrev    = 1'b0;
        firstFetch  = 1'b1;
        prevRnw     = 1'b1;
        prevSync    = 1'b0;
        for (a = 0; a < 65536; a++) begin
            mem[cpuPkg::addrT'(a)] = cpuPkg::byteT'(a ^ (a >> 8)) ^ 8'h5A;
        end
        buildProgram();
        mem[cpuPkg::RESET_VECTOR]         = START_PC[7:0];
        mem[cpuPkg::RESET_VECTOR + 16'd1] = START_PC[15:8];
        for (a = 0; a < 65536; a++) begin
            refMem[cpuPkg::addrT'(a)] = mem[cpuPkg::addrT'(a)];
        end
        refPc   = {refMem[cpuPkg::RESET_VECTOR + 16'd1], refMem[cpuPkg::RESET_VECTOR]};
        genDone = 1'b1;
        while (!endReached) begin
            @(posedge clk);
            #1;
            ready = ($random(seed) & 3) != 0; // low about one cycle in four.
            @(negedge clk);
            sampleCycle();
        end
        for (a = 'h400; a < 'h500; a++) begin
            checkByte(mem[cpuPkg::addrT'(a)], refMem[cpuPkg::addrT'(a)], "store area byte");
        end
        if (storeAddrQ.size() != 0) begin
            otherErrors++;
            $display("%0d stores never appeared on the bus", storeAddrQ.size());
        end
        $display("error counts: %0d address, %0d byte, %0d bit, %0d other",
                 addrErrors, byteErrors, bitErrors, otherErrors);
        if ((addrErrors + byteErrors + bitErrors + otherErrors) == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // four steps per instruction at most, with a wide margin for cycles where ready is low.
    initial begin
        wait (genDone);
        #(instrCount * 4 * BUS_DIVIDE * 8 * 20 + 2000);
        $display("timeout: the program never reached its final jump");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
